//--- compile.f
isa_pkg.sv
pipe_pkg.sv
regfile_if.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
cpu_asserts.sv
tb_top.sv

//--- cpu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_asserts (
    input wire logic           Clock,
    input wire logic           Reset,
    input wire isa_pkg::word_t InstrAddr,
    input wire isa_pkg::word_t DataAddr,
    input wire isa_pkg::word_t DataOut,
    input wire logic           ReadData,
    input wire logic           WriteData,
    input wire logic           DataDone,
    input wire logic           branch_taken
);

    localparam int             num_stores = 7;
    localparam isa_pkg::word_t skip_addr  = 16'h0050;  // only the skipped stores use it
    localparam isa_pkg::word_t idle_addr  = 16'd23;

    int             error_count;
    int             store_idx;
    int             after_last;    // cycles since the final store
    isa_pkg::word_t exp_addr;
    isa_pkg::word_t exp_data;
    logic           waiting;

    assign waiting = (ReadData || WriteData) && !DataDone;

    // stores the program must make, in order
    always_comb begin
        case (store_idx)
            0:       begin exp_addr = 16'h0040; exp_data = 16'h0008; end
            1:       begin exp_addr = 16'h0041; exp_data = 16'h1234; end
            2:       begin exp_addr = 16'h0042; exp_data = 16'h122C; end
            3:       begin exp_addr = 16'h0043; exp_data = 16'hBEEF; end  // load data
            4:       begin exp_addr = 16'h0044; exp_data = 16'h0003; end  // after failed bne
            5:       begin exp_addr = 16'h0045; exp_data = 16'h122C; end  // after failed bpl
            6:       begin exp_addr = 16'h0003; exp_data = 16'hFFFE; end  // register address
            default: begin exp_addr = 16'hFFFF; exp_data = 16'hFFFF; end
        endcase
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            store_idx  <= 0;
            after_last <= 0;
        end else begin
            if (WriteData && DataDone) begin
                store_idx <= store_idx + 1;
            end
            if (store_idx >= num_stores && after_last < 1000) begin
                after_last <= after_last + 1;
            end
        end
    end

    initial error_count = 0;

    reset_state: assert property (@(posedge Clock)
        $fell(Reset) |-> (InstrAddr == 16'h0000 && !ReadData && !WriteData))
    else begin
        $error("error %0t: bad fetch address or data strobe after reset", $time);
        error_count++;
    end

    strobes_exclusive: assert property (@(posedge Clock) disable iff (Reset)
        !(ReadData && WriteData))
    else begin
        $error("error %0t: read and write strobes high together", $time);
        error_count++;
    end

    request_held: assert property (@(posedge Clock) disable iff (Reset)
        $past(waiting) |-> (DataAddr == $past(DataAddr) && DataOut == $past(DataOut)
                            && ReadData == $past(ReadData) && WriteData == $past(WriteData)))
    else begin
        $error("error %0t: data request changed before DataDone", $time);
        error_count++;
    end

    store_matches: assert property (@(posedge Clock) disable iff (Reset)
        (WriteData && DataDone) |-> (store_idx < num_stores && DataAddr == exp_addr
                                     && DataOut == exp_data))
    else begin
        $error("error %0t: store %0d wrote %h to %h, expected %h to %h", $time,
               store_idx, DataOut, DataAddr, exp_data, exp_addr);
        error_count++;
    end

    no_skipped_store: assert property (@(posedge Clock) disable iff (Reset)
        WriteData |-> DataAddr != skip_addr)
    else begin
        $error("error %0t: store issued from a skipped instruction", $time);
        error_count++;
    end

    fetch_frozen: assert property (@(posedge Clock) disable iff (Reset)
        (waiting && !$past(branch_taken) && !$past(Reset)) |-> InstrAddr == $past(InstrAddr))
    else begin
        $error("error %0t: fetch address moved during a data wait", $time);
        error_count++;
    end

    idle_loop: assert property (@(posedge Clock) disable iff (Reset)
        (after_last >= 12) |-> (InstrAddr == idle_addr || InstrAddr == idle_addr + 16'd1))
    else begin
        $error("error %0t: fetch left the idle loop, address %h", $time, InstrAddr);
        error_count++;
    end

endmodule

`default_nettype wire

//--- cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  logic           Clock,
    input  logic           Reset,
    input  isa_pkg::word_t InstrIn,
    input  isa_pkg::word_t DataIn,
    input  logic           DataDone,
    output isa_pkg::word_t InstrAddr,
    output isa_pkg::word_t DataAddr,
    output isa_pkg::word_t DataOut,
    output logic           ReadData,
    output logic           WriteData
);

    isa_pkg::word_t       pc;
    logic                 stall;
    logic                 mem_wait;
    logic                 branch_taken;
    pipe_pkg::stage_rec_t fetch_rec;
    pipe_pkg::stage_rec_t dec_rec;
    pipe_pkg::stage_rec_t exec_rec;
    pipe_pkg::stage_rec_t mem_rec;
    pipe_pkg::stage_rec_t ret_rec;
    pipe_pkg::stage_rec_t wb_rec;

    regfile_if rf ();

    reg_file reg_file_inst (
        .Clock (Clock),
        .Reset (Reset),
        .rf    (rf.reg_side),
        .pc    (pc)
    );

    fetch_stage fetch_stage_inst (
        .Clock        (Clock),
        .Reset        (Reset),
        .pc           (pc),
        .InstrIn      (InstrIn),
        .stall        (stall),
        .mem_wait     (mem_wait),
        .branch_taken (branch_taken),
        .InstrAddr    (InstrAddr),
        .fetch_rec    (fetch_rec),
        .rf           (rf.wb_side)
    );

    decode_stage decode_stage_inst (
        .Clock     (Clock),
        .Reset     (Reset),
        .fetch_rec (fetch_rec),
        .exec_rec  (exec_rec),
        .mem_rec   (mem_rec),
        .ret_rec   (ret_rec),
        .wb_rec    (wb_rec),
        .mem_wait  (mem_wait),
        .rf        (rf.dec_side),
        .stall     (stall),
        .dec_rec   (dec_rec)
    );

    // status register stays local to execute
    execute_stage execute_stage_inst (
        .Clock    (Clock),
        .Reset    (Reset),
        .dec_rec  (dec_rec),
        .mem_wait (mem_wait),
        .exec_rec (exec_rec),
        .flags    ()
    );

    memory_stage memory_stage_inst (
        .Clock        (Clock),
        .Reset        (Reset),
        .exec_rec     (exec_rec),
        .DataIn       (DataIn),
        .DataDone     (DataDone),
        .DataAddr     (DataAddr),
        .DataOut      (DataOut),
        .ReadData     (ReadData),
        .WriteData    (WriteData),
        .mem_wait     (mem_wait),
        .branch_taken (branch_taken),
        .mem_rec      (mem_rec),
        .ret_rec      (ret_rec),
        .wb_rec       (wb_rec),
        .rf           (rf.wb_side)
    );

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                 Clock,
    input  logic                 Reset,
    input  pipe_pkg::stage_rec_t fetch_rec,
    input  pipe_pkg::stage_rec_t exec_rec,
    input  pipe_pkg::stage_rec_t mem_rec,
    input  pipe_pkg::stage_rec_t ret_rec,
    input  pipe_pkg::stage_rec_t wb_rec,
    input  logic                 mem_wait,
    regfile_if.dec_side          rf,
    output logic                 stall,
    output pipe_pkg::stage_rec_t dec_rec
);

    isa_pkg::word_t       ir;
    isa_pkg::opcode_e     opcode;
    isa_pkg::reg_idx_t    rx_field;
    isa_pkg::word_t       imm_sext;
    logic                 imm_flag;
    logic                 use_x;
    logic                 use_y;
    logic                 raw_hazard;
    logic                 branch_busy;
    pipe_pkg::stage_rec_t dec;
    pipe_pkg::stage_rec_t later [5];

    assign ir       = fetch_rec.out;
    assign opcode   = isa_pkg::opcode_e'(ir[isa_pkg::opc_msb:isa_pkg::opc_lsb]);
    assign imm_flag = ir[isa_pkg::imm_flag_bit];
    assign rx_field = ir[isa_pkg::rx_msb:isa_pkg::rx_lsb];
    assign imm_sext = isa_pkg::word_t'(signed'(ir[isa_pkg::imm_msb:0]));

    assign rf.rd_x = rx_field;
    assign rf.rd_y = ir[isa_pkg::ry_msb:0];

    always_comb begin
        dec = pipe_pkg::stage_nop;
        if (ir != '0) begin
            dec.rx  = rx_field;
            dec.ry  = ir[isa_pkg::ry_msb:0];
            dec.imm = imm_flag;
            dec.op1 = rf.x_data;
            dec.op2 = imm_flag ? imm_sext : rf.y_data;
            case (opcode)
                isa_pkg::op_mv: begin
                    dec.instr     = pipe_pkg::i_mov;
                    dec.alu_op    = pipe_pkg::alu_mov;
                    dec.writeback = 1'b1;
                end
                isa_pkg::op_mvt_b: begin
                    dec.writeback = 1'b1;
                    if (imm_flag) begin
                        dec.instr  = pipe_pkg::i_mvt;
                        dec.alu_op = pipe_pkg::alu_mov;
                        dec.op2    = {ir[isa_pkg::byte_msb:0], 8'h00};
                    end else begin
                        // target = own address + 1 + offset, written into r7
                        dec.instr  = pipe_pkg::i_branch;
                        dec.alu_op = pipe_pkg::alu_add;
                        dec.imm    = 1'b1;
                        dec.op1    = fetch_rec.op1 + 1'b1;
                        dec.op2    = imm_sext;
                        dec.rx     = isa_pkg::pc_reg;
                        dec.cond   = (rx_field == 3'd7) ? isa_pkg::cond_none
                                                        : isa_pkg::cond_e'(rx_field);
                    end
                end
                isa_pkg::op_add: begin
                    dec.instr     = pipe_pkg::i_add;
                    dec.alu_op    = pipe_pkg::alu_add;
                    dec.writeback = 1'b1;
                end
                isa_pkg::op_sub: begin
                    dec.instr     = pipe_pkg::i_sub;
                    dec.alu_op    = pipe_pkg::alu_sub;
                    dec.writeback = 1'b1;
                end
                isa_pkg::op_ld: begin
                    dec.instr     = pipe_pkg::i_load;  // op2 is the address
                    dec.read      = 1'b1;
                    dec.writeback = 1'b1;
                end
                isa_pkg::op_st: begin
                    dec.instr = pipe_pkg::i_store;  // op1 is the store data
                    dec.write = 1'b1;
                end
                isa_pkg::op_other: begin
                    if (imm_flag || ir[isa_pkg::cmp_zero_msb:isa_pkg::cmp_zero_lsb] == '0) begin
                        dec.instr        = pipe_pkg::i_cmp;
                        dec.alu_op       = pipe_pkg::alu_sub;
                        dec.update_flags = 1'b1;
                    end else begin
                        dec = pipe_pkg::stage_nop;
                    end
                end
                default: dec = pipe_pkg::stage_nop;  // logic ops not supported
            endcase
        end
    end

    // rX is checked conservatively, rY only in register form
    assign use_x = dec.instr != pipe_pkg::i_nop && dec.instr != pipe_pkg::i_branch;
    assign use_y = dec.instr != pipe_pkg::i_nop && !dec.imm;

    assign later = '{dec_rec, exec_rec, mem_rec, ret_rec, wb_rec};

    always_comb begin
        raw_hazard  = 1'b0;
        branch_busy = 1'b0;
        for (int i = 0; i < 5; i++) begin
            if (later[i].writeback && use_x && later[i].rx == dec.rx) begin
                raw_hazard = 1'b1;
            end
            if (later[i].writeback && use_y && later[i].rx == dec.ry) begin
                raw_hazard = 1'b1;
            end
            if (later[i].instr == pipe_pkg::i_branch) begin
                branch_busy = 1'b1;  // hold until the new r7 is known
            end
        end
    end

    assign stall = raw_hazard || branch_busy;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            dec_rec <= pipe_pkg::stage_nop;
        end else if (!mem_wait) begin
            dec_rec <= stall ? pipe_pkg::stage_nop : dec;  // bubble while held
        end
    end

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                 Clock,
    input  logic                 Reset,
    input  pipe_pkg::stage_rec_t dec_rec,
    input  logic                 mem_wait,
    output pipe_pkg::stage_rec_t exec_rec,
    output pipe_pkg::status_t    flags
);

    logic [isa_pkg::word_bits:0] sum;  // msb is carry-out
    logic                        cond_met;
    pipe_pkg::stage_rec_t        res;
    pipe_pkg::status_t           next_flags;

    always_comb begin
        case (dec_rec.alu_op)
            pipe_pkg::alu_mov: sum = {1'b0, dec_rec.op2};
            pipe_pkg::alu_add: sum = {1'b0, dec_rec.op1} + {1'b0, dec_rec.op2};
            pipe_pkg::alu_sub: sum = {1'b0, dec_rec.op1} + {1'b0, ~dec_rec.op2} + 1'b1;
            default:           sum = '0;
        endcase
    end

    always_comb begin
        case (dec_rec.cond)
            isa_pkg::cond_eq: cond_met = flags.zero;
            isa_pkg::cond_ne: cond_met = !flags.zero;
            isa_pkg::cond_cc: cond_met = !flags.carry;
            isa_pkg::cond_cs: cond_met = flags.carry;
            isa_pkg::cond_pl: cond_met = !flags.zero && !flags.negative;
            isa_pkg::cond_mi: cond_met = !flags.zero && flags.negative;
            default:          cond_met = 1'b1;
        endcase
    end

    always_comb begin
        res     = dec_rec;
        res.out = sum[isa_pkg::word_bits-1:0];
        if (!cond_met) begin
            res = pipe_pkg::stage_nop;  // branch not taken
        end
    end

    assign next_flags.negative = sum[isa_pkg::word_bits-1];
    assign next_flags.zero     = sum[isa_pkg::word_bits-1:0] == '0;
    assign next_flags.carry    = sum[isa_pkg::word_bits];  // op1 >= op2 unsigned

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            exec_rec <= pipe_pkg::stage_nop;
            flags    <= '0;
        end else if (!mem_wait) begin
            exec_rec <= res;
            if (res.update_flags) begin
                flags <= next_flags;  // only compare writes status
            end
        end
    end

endmodule

`default_nettype wire

//--- fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                 Clock,
    input  logic                 Reset,
    input  isa_pkg::word_t       pc,
    input  isa_pkg::word_t       InstrIn,
    input  logic                 stall,
    input  logic                 mem_wait,
    input  logic                 branch_taken,
    output isa_pkg::word_t       InstrAddr,
    output pipe_pkg::stage_rec_t fetch_rec,
    regfile_if.wb_side           rf
);

    logic                 advance;
    logic                 redirect;  // r7 already holds the branch target
    pipe_pkg::stage_rec_t fetched;

    assign advance   = !stall && !mem_wait && !branch_taken;
    assign InstrAddr = (advance && !redirect) ? pc + 1'b1 : pc;

    assign rf.pc_we   = advance;
    assign rf.pc_next = InstrAddr;

    always_comb begin
        fetched     = pipe_pkg::stage_nop;
        fetched.op1 = InstrAddr;  // own address, used for branch targets
        fetched.out = InstrIn;
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            fetch_rec <= pipe_pkg::stage_nop;
            redirect  <= 1'b0;
        end else if (branch_taken) begin
            fetch_rec <= pipe_pkg::stage_nop;  // drop the fall-through instruction
            redirect  <= 1'b1;
        end else if (advance) begin
            fetch_rec <= fetched;
            redirect  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int word_bits = 16;
    localparam int num_regs  = 8;
    localparam int reg_bits  = 3;

    typedef logic [word_bits-1:0] word_t;
    typedef logic [reg_bits-1:0]  reg_idx_t;

    // instruction word layout
    localparam int opc_msb      = 15;
    localparam int opc_lsb      = 13;
    localparam int imm_flag_bit = 12;
    localparam int rx_msb       = 11;
    localparam int rx_lsb       = 9;
    localparam int imm_msb      = 8;   // signed nine-bit immediate
    localparam int byte_msb     = 7;   // move-top byte
    localparam int ry_msb       = 2;
    localparam int cmp_zero_msb = 8;   // must be zero for register-form compare
    localparam int cmp_zero_lsb = 3;

    localparam reg_idx_t pc_reg = 3'd7;

    typedef enum logic [2:0] {
        op_mv    = 3'b000,
        op_mvt_b = 3'b001,  // imm set is mvt, clear is branch
        op_add   = 3'b010,
        op_sub   = 3'b011,
        op_ld    = 3'b100,
        op_st    = 3'b101,
        op_and   = 3'b110,
        op_other = 3'b111
    } opcode_e;

    // branch condition, lives in the rX field
    typedef enum logic [2:0] {
        cond_none = 3'd0,
        cond_eq   = 3'd1,
        cond_ne   = 3'd2,
        cond_cc   = 3'd3,
        cond_cs   = 3'd4,
        cond_pl   = 3'd5,
        cond_mi   = 3'd6
    } cond_e;

endpackage

`default_nettype wire

//--- memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  logic                 Clock,
    input  logic                 Reset,
    input  pipe_pkg::stage_rec_t exec_rec,
    input  isa_pkg::word_t       DataIn,
    input  logic                 DataDone,
    output isa_pkg::word_t       DataAddr,
    output isa_pkg::word_t       DataOut,
    output logic                 ReadData,
    output logic                 WriteData,
    output logic                 mem_wait,
    output logic                 branch_taken,
    output pipe_pkg::stage_rec_t mem_rec,
    output pipe_pkg::stage_rec_t ret_rec,
    output pipe_pkg::stage_rec_t wb_rec,
    regfile_if.wb_side           rf
);

    pipe_pkg::stage_rec_t returned;

    // request levels come straight from the memory-request register
    assign ReadData  = mem_rec.read;
    assign WriteData = mem_rec.write;
    assign DataAddr  = mem_rec.op2;
    assign DataOut   = mem_rec.op1;
    assign mem_wait  = (mem_rec.read || mem_rec.write) && !DataDone;

    always_comb begin
        returned = mem_rec;
        if (mem_rec.read) begin
            returned.out = DataIn;  // load data
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            mem_rec <= pipe_pkg::stage_nop;
            ret_rec <= pipe_pkg::stage_nop;
            wb_rec  <= pipe_pkg::stage_nop;
        end else begin
            if (mem_wait) begin
                ret_rec <= pipe_pkg::stage_nop;  // request held, bubble behind it
            end else begin
                mem_rec <= exec_rec;
                ret_rec <= returned;
            end
            wb_rec <= ret_rec;
        end
    end

    assign rf.we      = wb_rec.writeback;
    assign rf.wr_addr = wb_rec.rx;
    assign rf.wr_data = wb_rec.out;

    assign branch_taken = wb_rec.instr == pipe_pkg::i_branch;

endmodule

`default_nettype wire

//--- pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    typedef enum logic [3:0] {
        i_nop,
        i_mov,
        i_mvt,
        i_branch,
        i_add,
        i_sub,
        i_load,
        i_store,
        i_cmp
    } instr_e;

    typedef enum logic [1:0] {
        alu_none,
        alu_mov,
        alu_add,
        alu_sub
    } alu_op_e;

    typedef struct packed {
        logic negative;
        logic zero;
        logic carry;
    } status_t;

    // record carried from stage to stage
    typedef struct packed {
        isa_pkg::word_t    op1;
        isa_pkg::word_t    op2;
        isa_pkg::word_t    out;          // result, or instruction word in fetch
        isa_pkg::reg_idx_t rx;
        isa_pkg::reg_idx_t ry;
        logic              imm;
        logic              writeback;
        logic              read;
        logic              write;
        logic              update_flags;
        instr_e            instr;
        alu_op_e           alu_op;
        isa_pkg::cond_e    cond;
    } stage_rec_t;

    localparam stage_rec_t stage_nop = '{
        op1: '0, op2: '0, out: '0,
        rx: '0, ry: '0,
        imm: 1'b0, writeback: 1'b0, read: 1'b0, write: 1'b0, update_flags: 1'b0,
        instr: i_nop, alu_op: alu_none, cond: isa_pkg::cond_none
    };

endpackage

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic           Clock,
    input  logic           Reset,
    regfile_if.reg_side    rf,
    output isa_pkg::word_t pc
);

    isa_pkg::word_t regs [isa_pkg::num_regs];
    logic           wb_hits_pc;

    assign rf.x_data = regs[rf.rd_x];
    assign rf.y_data = regs[rf.rd_y];
    assign pc        = regs[isa_pkg::pc_reg];

    // a taken branch overrides the fetch increment
    assign wb_hits_pc = rf.we && (rf.wr_addr == isa_pkg::pc_reg);

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < isa_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
            regs[isa_pkg::pc_reg] <= '1;  // first fetch lands on address 0
        end else begin
            if (rf.we) begin
                regs[rf.wr_addr] <= rf.wr_data;
            end
            if (rf.pc_we && !wb_hits_pc) begin
                regs[isa_pkg::pc_reg] <= rf.pc_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- regfile_if.sv
`timescale 1ns/1ps
`default_nettype none

interface regfile_if;

    // decode read ports
    isa_pkg::reg_idx_t rd_x;
    isa_pkg::reg_idx_t rd_y;
    isa_pkg::word_t    x_data;
    isa_pkg::word_t    y_data;

    // writeback port
    logic              we;
    isa_pkg::reg_idx_t wr_addr;
    isa_pkg::word_t    wr_data;

    // r7 increment from fetch
    logic              pc_we;
    isa_pkg::word_t    pc_next;

    modport reg_side (
        input  rd_x, rd_y, we, wr_addr, wr_data, pc_we, pc_next,
        output x_data, y_data
    );

    modport dec_side (
        output rd_x, rd_y,
        input  x_data, y_data
    );

    modport wb_side (
        output we, wr_addr, wr_data, pc_we, pc_next
    );

endinterface

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the CPU regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top \
    -f compile.f \
    -o sim_tb_top
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

# let the testbench print its own verdict before stopping
./obj_dir/sim_tb_top +verilator+error+limit+100
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

//--- tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    logic           Clock;
    logic           Reset;
    isa_pkg::word_t InstrIn;
    isa_pkg::word_t DataIn;
    logic           DataDone;
    isa_pkg::word_t InstrAddr;
    isa_pkg::word_t DataAddr;
    isa_pkg::word_t DataOut;
    logic           ReadData;
    logic           WriteData;

    isa_pkg::word_t data_mem [65536];
    logic           busy;       // a request is being counted down
    int unsigned    wait_left;

    cpu_top cpu_top_inst (
        .Clock     (Clock),
        .Reset     (Reset),
        .InstrIn   (InstrIn),
        .DataIn    (DataIn),
        .DataDone  (DataDone),
        .InstrAddr (InstrAddr),
        .DataAddr  (DataAddr),
        .DataOut   (DataOut),
        .ReadData  (ReadData),
        .WriteData (WriteData)
    );

    bind cpu_top cpu_asserts asserts_inst (
        .Clock        (Clock),
        .Reset        (Reset),
        .InstrAddr    (InstrAddr),
        .DataAddr     (DataAddr),
        .DataOut      (DataOut),
        .ReadData     (ReadData),
        .WriteData    (WriteData),
        .DataDone     (DataDone),
        .branch_taken (branch_taken)
    );

    // test program, hand assembled
    function automatic isa_pkg::word_t program_word(input isa_pkg::word_t addr);
        case (addr)
            16'd0:   program_word = 16'h1205;  // mv  r1, #5
            16'd1:   program_word = 16'h1403;  // mv  r2, #3
            16'd2:   program_word = 16'h4202;  // add r1, r2
            16'd3:   program_word = 16'hB240;  // st  r1, [0x40]
            16'd4:   program_word = 16'h3612;  // mvt r3, #0x12
            16'd5:   program_word = 16'h5634;  // add r3, #0x34
            16'd6:   program_word = 16'hB641;  // st  r3, [0x41]
            16'd7:   program_word = 16'h6601;  // sub r3, r1
            16'd8:   program_word = 16'hB642;  // st  r3, [0x42]
            16'd9:   program_word = 16'h9820;  // ld  r4, [0x20]
            16'd10:  program_word = 16'hB843;  // st  r4, [0x43]
            16'd11:  program_word = 16'hF208;  // cmp r1, #8
            16'd12:  program_word = 16'h2402;  // bne +2, not taken
            16'd13:  program_word = 16'hB444;  // st  r2, [0x44]
            16'd14:  program_word = 16'h2201;  // beq +1, taken
            16'd15:  program_word = 16'hB250;  // skipped
            16'd16:  program_word = 16'hE401;  // cmp r2, r1
            16'd17:  program_word = 16'h2601;  // bcc +1, taken
            16'd18:  program_word = 16'hB250;  // skipped
            16'd19:  program_word = 16'h2A01;  // bpl +1, not taken
            16'd20:  program_word = 16'hB645;  // st  r3, [0x45]
            16'd21:  program_word = 16'h1BFE;  // mv  r5, #-2
            16'd22:  program_word = 16'hAA02;  // st  r5, [r2]
            16'd23:  program_word = 16'h21FF;  // b   self
            default: program_word = 16'h0000;
        endcase
    endfunction

    // instruction port answers in the same cycle
    always_comb InstrIn = program_word(InstrAddr);

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    // data port with 0 to 3 cycles of extra latency
    always @(posedge Clock) begin
        if (Reset) begin
            DataDone  <= 1'b0;
            DataIn    <= '0;
            busy      = 1'b0;
            wait_left = 0;
        end else if (DataDone) begin
            if (WriteData) begin
                data_mem[DataAddr] = DataOut;
            end
            DataDone <= 1'b0;
            busy     = 1'b0;
        end else if (ReadData || WriteData) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = $urandom % 4;
            end
            if (wait_left == 0) begin
                DataDone <= 1'b1;
                DataIn   <= data_mem[DataAddr];
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    // first failed check ends the run
    always @(negedge Clock) begin
        if (cpu_top_inst.asserts_inst.error_count != 0) begin
            $display("Regression failed");
            $fatal(1, "a protocol or store check failed, see the error above");
        end
    end

    initial begin
        int unsigned seed_val;
        int          cycles;
        logic        seen_last;

        Reset    <= 1'b1;
        DataDone <= 1'b0;
        DataIn   <= '0;
        seed_val = $urandom(32'h848);
        for (int i = 0; i < 65536; i++) begin
            data_mem[i] = isa_pkg::word_t'(i) ^ 16'hA5C3;
        end
        data_mem[16'h0020] = 16'hBEEF;  // value for the load

        repeat (8) @(posedge Clock);
        Reset <= 1'b0;

        cycles    = 0;
        seen_last = 1'b0;
        while (!seen_last && cycles < 2000) begin
            @(posedge Clock);
            if (WriteData && DataDone && DataAddr == 16'h0003) begin
                seen_last = 1'b1;
            end
            cycles++;
        end

        if (!seen_last) begin
            $display("Regression failed");
            $fatal(1, "timeout: the program never reached its last store");
        end else begin
            // let fetch settle in the idle loop
            for (int n = 0; n < 20; n++) begin
                @(posedge Clock);
            end
            if (cpu_top_inst.asserts_inst.error_count == 0) begin
                $display("Regression passed");
                $finish;
            end else begin
                $display("Regression failed");
                $fatal(1, "checks failed during the run");
            end
        end
    end

endmodule

`default_nettype wire
